//--- hdl/event_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module event_fifo
   import phold_pkg::*;
#(
   parameter int HIST_DEPTH_LOG2 = 4
) (
   input  logic clk,
   input  logic rst,
   input  logic clear,
   input  logic push,
   input  hist_entry_t din,
   input  logic pop,
   output hist_entry_t dout,
   output logic empty,
   output logic [HIST_DEPTH_LOG2:0] count
);

   localparam int DEPTH = 2 ** HIST_DEPTH_LOG2;

   hist_entry_t mem [DEPTH];
   logic [HIST_DEPTH_LOG2-1:0] wr_ptr;
   logic [HIST_DEPTH_LOG2-1:0] rd_ptr;
   logic do_push;
   logic do_pop;

   assign empty = (count == '0);
   assign do_pop = pop && !empty;
   assign do_push = push && (count != (HIST_DEPTH_LOG2 + 1)'(DEPTH));
   // head is visible without a read strobe
   assign dout = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (rst || clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + {{HIST_DEPTH_LOG2{1'b0}}, do_push}
                  - {{HIST_DEPTH_LOG2{1'b0}}, do_pop};
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= din;
      end
   end

endmodule

`default_nettype wire

//--- hdl/event_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module event_sequencer
   import phold_pkg::*;
#(
   parameter int MIN_GAP = 10
) (
   input  logic clk,
   input  logic rst,
   input  logic event_valid,
   input  event_msg_t event_msg,
   input  sim_time_t global_time,
   input  logic [RND_WID-1:0] random_in,
   output logic ready,
   output logic out_valid,
   output event_msg_t out_msg,
   input  logic ack,
   output hist_op_t hist_op,
   output logic hist_start,
   output lp_id_t cur_lp,
   input  logic hist_done,
   output event_msg_t cur_event,
   output sim_time_t gvt,
   input  logic discard_cur,
   input  logic send_cancel,
   input  event_msg_t cancel_msg,
   output logic gen_push,
   output hist_entry_t gen_entry,
   input  hist_entry_t rbk_entry,
   input  logic rbk_empty,
   output logic rbk_pop,
   output logic buf_clear
);

   core_state_t state;
   core_state_t state_nxt;
   logic [RND_WID-1:0] rnd;
   logic [3:0] delay_cnt;
   logic accept;
   logic delay_done;
   logic ack_more;
   // 0 sends the cancel of a rollback entry, 1 its re-execution
   logic rbk_phase;
   sim_time_t gap;
   sim_time_t new_time;
   event_msg_t new_msg;
   event_msg_t first_msg;
   event_msg_t rbk_cncl_msg;
   event_msg_t rbk_evt_msg;

   assign accept = ready && event_valid;
   assign buf_clear = accept;
   assign cur_lp = cur_event.target;
   assign delay_done = (delay_cnt == rnd[19:16]);
   assign ack_more = (state == WAIT_ACK) && ack && !rbk_empty;
   assign rbk_pop = ack_more && rbk_phase;
   assign gen_push = (state == GEN_EVT) && !discard_cur;

   // next event keeps at least MIN_GAP from the current one
   assign gap = TIME_WID'(MIN_GAP) + TIME_WID'(rnd[5:0]);
   assign new_time = cur_event.evt_time + gap;
   assign new_msg = '{pad: '0, evt_type: EVT_REGULAR, target: rnd[10:8], evt_time: new_time};
   assign gen_entry = '{pad: '0, target: rnd[10:8], offset: gap[OFFSET_WID-1:0],
                        evt_type: cur_event.evt_type, evt_time: cur_event.evt_time};

   assign rbk_cncl_msg = '{pad: '0, evt_type: EVT_CANCEL, target: rbk_entry.target,
                           evt_time: rbk_entry.evt_time + TIME_WID'(rbk_entry.offset)};
   assign rbk_evt_msg = '{pad: '0, evt_type: EVT_REGULAR, target: cur_event.target,
                          evt_time: rbk_entry.evt_time};

   always_comb begin
      if (discard_cur) begin
         first_msg = send_cancel ? cancel_msg : NULL_MSG;
      end else if (cur_event.evt_type == EVT_CANCEL) begin
         first_msg = NULL_MSG;
      end else begin
         first_msg = new_msg;
      end
   end

   always_comb begin
      case (state)
         READ_HIST: hist_op = HIST_READ;
         WRITE_HIST: hist_op = HIST_WRITE;
         default: hist_op = HIST_NONE;
      endcase
   end

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: if (accept) state_nxt = READ_HIST;
         READ_HIST: if (hist_done) state_nxt = PROC_DELAY;
         PROC_DELAY: if (delay_done) state_nxt = GEN_EVT;
         GEN_EVT: state_nxt = WRITE_HIST;
         WRITE_HIST: if (hist_done) state_nxt = SEND_EVT;
         SEND_EVT: state_nxt = WAIT_ACK;
         WAIT_ACK: if (ack && rbk_empty) state_nxt = IDLE;
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IDLE;
         ready <= 1'b1;
         out_valid <= 1'b0;
         hist_start <= 1'b0;
         delay_cnt <= '0;
         rbk_phase <= 1'b0;
      end else begin
         state <= state_nxt;
         ready <= (state_nxt == IDLE);
         // start the read on accept and the write-back after GEN_EVT
         hist_start <= accept || (state == GEN_EVT);
         delay_cnt <= (state == PROC_DELAY) ? delay_cnt + 1'b1 : '0;
         if (state == SEND_EVT) begin
            out_valid <= 1'b1;
            rbk_phase <= 1'b0;
         end else if (state == WAIT_ACK && ack) begin
            if (rbk_empty) begin
               out_valid <= 1'b0;
            end else begin
               rbk_phase <= !rbk_phase;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cur_event <= event_msg;
         gvt <= global_time;
         rnd <= random_in;
      end
      if (state == SEND_EVT) begin
         out_msg <= first_msg;
      end else if (ack_more) begin
         out_msg <= rbk_phase ? rbk_evt_msg : rbk_cncl_msg;
      end
   end

endmodule

`default_nettype wire

//--- hdl/hist_filter.sv
`timescale 1ns/1ps
`default_nettype none

module hist_filter
   import phold_pkg::*;
(
   input  logic clk,
   input  logic rst,
   input  logic buf_clear,
   input  logic rd_valid,
   input  hist_entry_t rd_entry,
   input  event_msg_t cur_event,
   input  sim_time_t gvt,
   output logic discard_cur,
   output logic send_cancel,
   output event_msg_t cancel_msg,
   input  logic gen_push,
   input  hist_entry_t gen_entry,
   output logic keep_push,
   output hist_entry_t keep_entry,
   output logic rbk_push,
   output hist_entry_t rbk_entry_in
);

   logic is_expired;
   logic is_match;
   logic is_rollback;
   logic keep_q;
   hist_entry_t entry_q;
   event_msg_t match_msg;

   always_comb begin
      is_expired = rd_entry.evt_time < gvt;
      // only the first cancelling pair annihilates
      is_match = (rd_entry.evt_type != cur_event.evt_type)
                 && (rd_entry.evt_time == cur_event.evt_time) && !discard_cur;
      is_rollback = (rd_entry.evt_type == EVT_REGULAR) && (cur_event.evt_type == EVT_REGULAR)
                    && (rd_entry.evt_time > cur_event.evt_time);
   end

   // undo what the stored event already sent
   assign match_msg = '{pad: '0, evt_type: EVT_CANCEL, target: rd_entry.target,
                        evt_time: rd_entry.evt_time + TIME_WID'(rd_entry.offset)};

   // generated entry never overlaps a kept entry in time
   assign keep_push = keep_q || gen_push;
   assign keep_entry = gen_push ? gen_entry : entry_q;
   assign rbk_entry_in = entry_q;

   always_ff @(posedge clk) begin
      if (rst || buf_clear) begin
         discard_cur <= 1'b0;
         send_cancel <= 1'b0;
         keep_q <= 1'b0;
         rbk_push <= 1'b0;
      end else begin
         keep_q <= 1'b0;
         rbk_push <= 1'b0;
         if (rd_valid) begin
            if (is_expired) begin
               // past gvt, can never roll back
            end else if (is_match) begin
               discard_cur <= 1'b1;
               send_cancel <= (cur_event.evt_type == EVT_CANCEL);
            end else if (is_rollback) begin
               rbk_push <= 1'b1;
            end else begin
               keep_q <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_valid) begin
         entry_q <= rd_entry;
      end
      if (rd_valid && !is_expired && is_match) begin
         cancel_msg <= match_msg;
      end
   end

endmodule

`default_nettype wire

//--- hdl/hist_port.sv
`timescale 1ns/1ps
`default_nettype none

module hist_port
   import phold_pkg::*;
#(
   parameter int HIST_DEPTH_LOG2 = 4
) (
   input  logic clk,
   input  logic rst,
   input  hist_op_t hist_op,
   input  logic hist_start,
   input  lp_id_t cur_lp,
   input  logic [HIST_DEPTH_LOG2-1:0] hist_size,
   output logic hist_done,
   output logic hist_rq,
   output logic hist_wr_en,
   output logic [LP_WID+HIST_DEPTH_LOG2-1:0] hist_addr,
   output hist_entry_t hist_wr_data,
   input  hist_entry_t hist_rd_data,
   input  logic hist_grant,
   output logic rd_valid,
   output hist_entry_t rd_entry,
   input  hist_entry_t buf_data,
   input  logic [HIST_DEPTH_LOG2:0] buf_count,
   output logic buf_pop
);

   logic [HIST_DEPTH_LOG2:0] start_count;
   logic [HIST_DEPTH_LOG2:0] acc_count;
   logic [HIST_DEPTH_LOG2-1:0] idx;
   logic granted;
   logic last;

   assign start_count = (hist_op == HIST_READ) ? {1'b0, hist_size} : buf_count;
   assign granted = hist_rq && hist_grant;
   assign last = ({1'b0, idx} == acc_count - 1'b1);

   // LP region base is cur_lp * 2^HIST_DEPTH_LOG2
   assign hist_addr = {cur_lp, idx};
   // buffer head stays put until the grant pops it
   assign hist_wr_data = buf_data;
   assign buf_pop = granted && hist_wr_en;

   always_ff @(posedge clk) begin
      if (rst) begin
         hist_rq <= 1'b0;
         hist_wr_en <= 1'b0;
         hist_done <= 1'b0;
         rd_valid <= 1'b0;
         acc_count <= '0;
         idx <= '0;
      end else begin
         hist_done <= 1'b0;
         rd_valid <= 1'b0;
         if (hist_start) begin
            acc_count <= start_count;
            idx <= '0;
            if (start_count == '0) begin
               hist_done <= 1'b1;
            end else begin
               hist_rq <= 1'b1;
               hist_wr_en <= (hist_op == HIST_WRITE);
            end
         end else if (granted) begin
            rd_valid <= !hist_wr_en;
            idx <= idx + 1'b1;
            // request stays up for the next entry
            if (last) begin
               hist_rq <= 1'b0;
               hist_wr_en <= 1'b0;
               hist_done <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (granted && !hist_wr_en) begin
         rd_entry <= hist_rd_data;
      end
   end

endmodule

`default_nettype wire

//--- hdl/phold_core.sv
`timescale 1ns/1ps
`default_nettype none

module phold_core
   import phold_pkg::*;
#(
   parameter int HIST_DEPTH_LOG2 = 4,
   parameter int MIN_GAP = 10
) (
   input  logic clk,
   input  logic rst,
   input  logic event_valid,
   input  event_msg_t event_msg,
   input  sim_time_t global_time,
   input  logic [RND_WID-1:0] random_in,
   output logic ready,
   output logic out_valid,
   output event_msg_t out_msg,
   input  logic ack,
   output logic hist_rq,
   output logic hist_wr_en,
   output logic [LP_WID+HIST_DEPTH_LOG2-1:0] hist_addr,
   output hist_entry_t hist_wr_data,
   input  hist_entry_t hist_rd_data,
   input  logic hist_grant,
   input  logic [HIST_DEPTH_LOG2-1:0] hist_size
);

   hist_op_t hist_op;
   logic hist_start;
   logic hist_done;
   lp_id_t cur_lp;
   event_msg_t cur_event;
   sim_time_t gvt;
   logic discard_cur;
   logic send_cancel;
   event_msg_t cancel_msg;
   logic gen_push;
   hist_entry_t gen_entry;
   logic buf_clear;

   // read path into the filter
   logic rd_valid;
   hist_entry_t rd_entry;

   // history buffer, refilled by the filter and drained by the write-back
   logic keep_push;
   hist_entry_t keep_entry;
   hist_entry_t buf_data;
   logic [HIST_DEPTH_LOG2:0] buf_count;
   logic buf_pop;

   // rollback buffer, drained while sending messages
   logic rbk_push;
   hist_entry_t rbk_entry_in;
   hist_entry_t rbk_entry;
   logic rbk_empty;
   logic rbk_pop;

   event_sequencer #(
      .MIN_GAP(MIN_GAP)
   ) u_event_sequencer (
      .clk(clk),
      .rst(rst),
      .event_valid(event_valid),
      .event_msg(event_msg),
      .global_time(global_time),
      .random_in(random_in),
      .ready(ready),
      .out_valid(out_valid),
      .out_msg(out_msg),
      .ack(ack),
      .hist_op(hist_op),
      .hist_start(hist_start),
      .cur_lp(cur_lp),
      .hist_done(hist_done),
      .cur_event(cur_event),
      .gvt(gvt),
      .discard_cur(discard_cur),
      .send_cancel(send_cancel),
      .cancel_msg(cancel_msg),
      .gen_push(gen_push),
      .gen_entry(gen_entry),
      .rbk_entry(rbk_entry),
      .rbk_empty(rbk_empty),
      .rbk_pop(rbk_pop),
      .buf_clear(buf_clear)
   );

   hist_port #(
      .HIST_DEPTH_LOG2(HIST_DEPTH_LOG2)
   ) u_hist_port (
      .clk(clk),
      .rst(rst),
      .hist_op(hist_op),
      .hist_start(hist_start),
      .cur_lp(cur_lp),
      .hist_size(hist_size),
      .hist_done(hist_done),
      .hist_rq(hist_rq),
      .hist_wr_en(hist_wr_en),
      .hist_addr(hist_addr),
      .hist_wr_data(hist_wr_data),
      .hist_rd_data(hist_rd_data),
      .hist_grant(hist_grant),
      .rd_valid(rd_valid),
      .rd_entry(rd_entry),
      .buf_data(buf_data),
      .buf_count(buf_count),
      .buf_pop(buf_pop)
   );

   hist_filter u_hist_filter (
      .clk(clk),
      .rst(rst),
      .buf_clear(buf_clear),
      .rd_valid(rd_valid),
      .rd_entry(rd_entry),
      .cur_event(cur_event),
      .gvt(gvt),
      .discard_cur(discard_cur),
      .send_cancel(send_cancel),
      .cancel_msg(cancel_msg),
      .gen_push(gen_push),
      .gen_entry(gen_entry),
      .keep_push(keep_push),
      .keep_entry(keep_entry),
      .rbk_push(rbk_push),
      .rbk_entry_in(rbk_entry_in)
   );

   event_fifo #(
      .HIST_DEPTH_LOG2(HIST_DEPTH_LOG2)
   ) u_hist_buf (
      .clk(clk),
      .rst(rst),
      .clear(buf_clear),
      .push(keep_push),
      .din(keep_entry),
      .pop(buf_pop),
      .dout(buf_data),
      .empty(),
      .count(buf_count)
   );

   event_fifo #(
      .HIST_DEPTH_LOG2(HIST_DEPTH_LOG2)
   ) u_rbk_buf (
      .clk(clk),
      .rst(rst),
      .clear(buf_clear),
      .push(rbk_push),
      .din(rbk_entry_in),
      .pop(rbk_pop),
      .dout(rbk_entry),
      .empty(rbk_empty),
      .count()
   );

endmodule

`default_nettype wire

//--- hdl/phold_pkg.sv
`default_nettype none

package phold_pkg;

   localparam int TIME_WID = 16;
   localparam int LP_WID = 3;
   localparam int OFFSET_WID = 8;
   localparam int RND_WID = 24;

   typedef logic [TIME_WID-1:0] sim_time_t;
   typedef logic [LP_WID-1:0] lp_id_t;

   typedef enum logic [0:0] {
      EVT_REGULAR = 1'b0,
      EVT_CANCEL = 1'b1
   } evt_type_t;

   // message as seen on the event input and output ports
   typedef struct packed {
      logic [11:0] pad;
      evt_type_t evt_type;
      lp_id_t target;
      sim_time_t evt_time;
   } event_msg_t;

   // one processed event and the event it generated
   typedef struct packed {
      logic [3:0] pad;
      lp_id_t target;
      logic [OFFSET_WID-1:0] offset;
      evt_type_t evt_type;
      sim_time_t evt_time;
   } hist_entry_t;

   typedef enum logic [2:0] {
      IDLE,
      READ_HIST,
      PROC_DELAY,
      GEN_EVT,
      WRITE_HIST,
      SEND_EVT,
      WAIT_ACK
   } core_state_t;

   typedef enum logic [1:0] {
      HIST_NONE,
      HIST_READ,
      HIST_WRITE
   } hist_op_t;

   // sent when processing produces no real event
   localparam event_msg_t NULL_MSG = '{pad: '0, evt_type: EVT_CANCEL, target: '0, evt_time: '0};

endpackage

`default_nettype wire

//--- project.f
hdl/phold_pkg.sv
hdl/event_fifo.sv
hdl/hist_filter.sv
hdl/hist_port.sv
hdl/event_sequencer.sv
hdl/phold_core.sv
sim/phold_core_props.sv
sim/tb_phold_core.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the phold core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
   --top-module tb_phold_core \
   -f project.f \
   -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "test failed" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
echo "simulation finished without failures"

//--- sim/phold_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module phold_core_props
   import phold_pkg::*;
#(
   parameter int HIST_DEPTH_LOG2 = 4
) (
   input logic clk,
   input logic rst,
   input logic ready,
   input logic out_valid,
   input event_msg_t out_msg,
   input logic ack,
   input logic hist_rq,
   input logic hist_grant,
   input logic [LP_WID+HIST_DEPTH_LOG2-1:0] hist_addr
);

   // message holds until the receiver takes it
   a_out_msg_stable: assert property (@(posedge clk) disable iff (rst)
      (out_valid && !ack) |=> (out_valid && $stable(out_msg)))
      else $error("out_msg changed before ack");

   // memory request holds until granted
   a_hist_addr_stable: assert property (@(posedge clk) disable iff (rst)
      (hist_rq && !hist_grant) |=> (hist_rq && $stable(hist_addr)))
      else $error("hist_addr changed before grant");

   a_ready_out_excl: assert property (@(posedge clk) disable iff (rst)
      !(ready && out_valid))
      else $error("ready and out_valid high together");

endmodule

bind phold_core phold_core_props #(
   .HIST_DEPTH_LOG2(HIST_DEPTH_LOG2)
) u_phold_core_props (
   .clk(clk),
   .rst(rst),
   .ready(ready),
   .out_valid(out_valid),
   .out_msg(out_msg),
   .ack(ack),
   .hist_rq(hist_rq),
   .hist_grant(hist_grant),
   .hist_addr(hist_addr)
);

`default_nettype wire

//--- sim/tb_phold_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_phold_core
   import phold_pkg::*;
();

   localparam int HIST_DEPTH_LOG2 = 4;
   localparam int MIN_GAP = 10;
   localparam int ADDR_WID = LP_WID + HIST_DEPTH_LOG2;
   localparam int WAIT_LIMIT = 500;

   typedef logic [ADDR_WID-1:0] hist_addr_t;

   logic clk;
   logic rst;
   logic event_valid;
   event_msg_t event_msg;
   sim_time_t global_time;
   logic [RND_WID-1:0] random_in;
   logic ready;
   logic out_valid;
   event_msg_t out_msg;
   logic ack;
   logic hist_rq;
   logic hist_wr_en;
   hist_addr_t hist_addr;
   hist_entry_t hist_wr_data;
   hist_entry_t hist_rd_data;
   logic hist_grant;
   logic [HIST_DEPTH_LOG2-1:0] hist_size;

   integer seed = 32'he5bd3747;
   int n_checks = 0;
   int n_errors = 0;

   // history memory, 8 LP regions
   hist_entry_t mem [2**ADDR_WID];
   logic [HIST_DEPTH_LOG2-1:0] lp_size [8];
   // every write the memory has granted, in order
   hist_entry_t wr_data_q[$];
   hist_addr_t wr_addr_q[$];

   hist_entry_t preload_q[$];
   event_msg_t exp_msgs[$];
   hist_entry_t exp_writes[$];
   event_msg_t got_msgs[$];
   hist_entry_t ev_writes[$];
   hist_addr_t ev_addrs[$];

   phold_core #(
      .HIST_DEPTH_LOG2(HIST_DEPTH_LOG2),
      .MIN_GAP(MIN_GAP)
   ) u_phold_core (
      .clk(clk),
      .rst(rst),
      .event_valid(event_valid),
      .event_msg(event_msg),
      .global_time(global_time),
      .random_in(random_in),
      .ready(ready),
      .out_valid(out_valid),
      .out_msg(out_msg),
      .ack(ack),
      .hist_rq(hist_rq),
      .hist_wr_en(hist_wr_en),
      .hist_addr(hist_addr),
      .hist_wr_data(hist_wr_data),
      .hist_rd_data(hist_rd_data),
      .hist_grant(hist_grant),
      .hist_size(hist_size)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // grants after 0 to 3 idle cycles, low for at least one cycle between grants
   initial begin : memory_model
      int wait_left;
      logic busy;
      hist_grant = 1'b0;
      hist_rd_data = '0;
      wait_left = 0;
      busy = 1'b0;
      forever begin
         @(negedge clk);
         if (hist_grant) begin
            hist_grant = 1'b0;
         end else if (hist_rq) begin
            if (!busy) begin
               busy = 1'b1;
               wait_left = $unsigned($random(seed)) % 4;
            end
            if (wait_left == 0) begin
               busy = 1'b0;
               hist_grant = 1'b1;
               if (hist_wr_en) begin
                  wr_data_q.push_back(hist_wr_data);
                  wr_addr_q.push_back(hist_addr);
               end else begin
                  hist_rd_data = mem[hist_addr];
               end
            end else begin
               wait_left--;
            end
         end
      end
   end

   function automatic event_msg_t mk_msg(evt_type_t ty, lp_id_t tgt, sim_time_t t);
      event_msg_t m;
      m = '0;
      m.evt_type = ty;
      m.target = tgt;
      m.evt_time = t;
      return m;
   endfunction

   function automatic hist_entry_t mk_entry(evt_type_t ty, sim_time_t t, lp_id_t tgt,
                                            logic [OFFSET_WID-1:0] off);
      hist_entry_t e;
      e = '0;
      e.evt_type = ty;
      e.evt_time = t;
      e.target = tgt;
      e.offset = off;
      return e;
   endfunction

   // delay, target and gap fields set, the rest random
   function automatic logic [RND_WID-1:0] make_rnd(logic [3:0] delay, lp_id_t tgt,
                                                    logic [5:0] gap);
      logic [RND_WID-1:0] r;
      r = RND_WID'($random(seed));
      r[19:16] = delay;
      r[10:8] = tgt;
      r[5:0] = gap;
      return r;
   endfunction

   function automatic event_msg_t new_event_msg(event_msg_t cur, logic [RND_WID-1:0] rnd);
      return mk_msg(EVT_REGULAR, rnd[10:8],
                    cur.evt_time + sim_time_t'(MIN_GAP) + sim_time_t'(rnd[5:0]));
   endfunction

   function automatic hist_entry_t new_entry(event_msg_t cur, logic [RND_WID-1:0] rnd);
      return mk_entry(cur.evt_type, cur.evt_time, rnd[10:8],
                      OFFSET_WID'(MIN_GAP) + OFFSET_WID'(rnd[5:0]));
   endfunction

   // cancels the event that a stored entry generated
   function automatic event_msg_t cancel_of(hist_entry_t e);
      return mk_msg(EVT_CANCEL, e.target, e.evt_time + sim_time_t'(e.offset));
   endfunction

   task automatic check_msg(input event_msg_t got, input event_msg_t exp, input string what);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_entry(input hist_entry_t got, input hist_entry_t exp,
                              input string what);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_addr(input hist_addr_t got, input hist_addr_t exp, input string what);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_level(input logic got, input logic exp, input string what);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      n_checks++;
      if (got != exp) begin
         n_errors++;
         $display("CHECK FAILED at %0t: %s, got %0d expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic stop_on_timeout(input string why);
      $display("timeout at %0t: %s", $time, why);
      $display("checks run: %0d, errors: %0d", n_checks, n_errors);
      $display("test failed");
      $finish;
   endtask

   task automatic wait_ready();
      int cycles;
      cycles = 0;
      while (!ready) begin
         @(negedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT) stop_on_timeout("ready did not return");
      end
   endtask

   task automatic take_msg(input int hold, output event_msg_t m);
      int cycles;
      cycles = 0;
      while (!out_valid) begin
         @(negedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT) stop_on_timeout("no output message arrived");
      end
      repeat (hold) @(negedge clk);
      check_level(ready, 1'b0, "ready while a message waits for ack");
      m = out_msg;
      ack = 1'b1;
      @(negedge clk);
      ack = 1'b0;
   endtask

   task automatic load_history(input lp_id_t lp);
      for (int i = 0; i < preload_q.size(); i++) begin
         mem[{lp, HIST_DEPTH_LOG2'(i)}] = preload_q[i];
      end
      lp_size[lp] = HIST_DEPTH_LOG2'(preload_q.size());
   endtask

   task automatic clear_expect();
      preload_q.delete();
      exp_msgs.delete();
      exp_writes.delete();
   endtask

   // one event through the core, ack held up to max_hold cycles per message
   task automatic run_event(input event_msg_t ev, input sim_time_t gvt_in,
                            input logic [RND_WID-1:0] rnd, input int max_hold);
      event_msg_t m;
      int hold;
      int wr_base;
      got_msgs.delete();
      ev_writes.delete();
      ev_addrs.delete();
      wait_ready();
      wr_base = wr_data_q.size();
      event_valid = 1'b1;
      event_msg = ev;
      global_time = gvt_in;
      random_in = rnd;
      hist_size = lp_size[ev.target];
      @(negedge clk);
      event_valid = 1'b0;
      check_level(ready, 1'b0, "ready after accept");
      for (int i = 0; i < exp_msgs.size(); i++) begin
         hold = $unsigned($random(seed)) % (max_hold + 1);
         take_msg(hold, m);
         got_msgs.push_back(m);
      end
      check_level(ready, 1'b1, "ready after last ack");
      check_level(out_valid, 1'b0, "out_valid after last ack");
      wait_ready();
      for (int i = wr_base; i < wr_data_q.size(); i++) begin
         ev_writes.push_back(wr_data_q[i]);
         ev_addrs.push_back(wr_addr_q[i]);
         mem[wr_addr_q[i]] = wr_data_q[i];
      end
      lp_size[ev.target] = HIST_DEPTH_LOG2'(ev_writes.size());
   endtask

   task automatic compare_results(input lp_id_t lp);
      int n;
      for (int i = 0; i < exp_msgs.size(); i++) begin
         check_msg(got_msgs[i], exp_msgs[i], $sformatf("message %0d", i));
      end
      check_count(ev_writes.size(), exp_writes.size(), "history write count");
      n = (ev_writes.size() < exp_writes.size()) ? ev_writes.size() : exp_writes.size();
      for (int i = 0; i < n; i++) begin
         check_entry(ev_writes[i], exp_writes[i], $sformatf("history write %0d", i));
         check_addr(ev_addrs[i], {lp, HIST_DEPTH_LOG2'(i)}, $sformatf("write address %0d", i));
      end
   endtask

   task automatic test_empty_history();
      event_msg_t ev;
      logic [RND_WID-1:0] rnd;
      check_level(ready, 1'b1, "ready after reset");
      check_level(out_valid, 1'b0, "out_valid after reset");
      check_level(hist_rq, 1'b0, "hist_rq after reset");
      check_level(hist_wr_en, 1'b0, "hist_wr_en after reset");
      clear_expect();
      ev = mk_msg(EVT_REGULAR, 3'd2, 16'd100);
      rnd = make_rnd(4'd3, 3'd5, 6'd26);
      exp_msgs.push_back(new_event_msg(ev, rnd));
      exp_writes.push_back(new_entry(ev, rnd));
      run_event(ev, 16'd50, rnd, 1);
      compare_results(3'd2);
   endtask

   task automatic test_expire_and_keep();
      event_msg_t ev;
      logic [RND_WID-1:0] rnd;
      clear_expect();
      preload_q.push_back(mk_entry(EVT_REGULAR, 16'd50, 3'd1, 8'd20));
      preload_q.push_back(mk_entry(EVT_REGULAR, 16'd120, 3'd2, 8'd11));
      preload_q.push_back(mk_entry(EVT_CANCEL, 16'd90, 3'd3, 8'd12));
      preload_q.push_back(mk_entry(EVT_CANCEL, 16'd150, 3'd4, 8'd13));
      preload_q.push_back(mk_entry(EVT_REGULAR, 16'd180, 3'd5, 8'd14));
      load_history(3'd3);
      ev = mk_msg(EVT_REGULAR, 3'd3, 16'd200);
      rnd = make_rnd(4'd0, 3'd1, 6'd5);
      exp_msgs.push_back(new_event_msg(ev, rnd));
      exp_writes.push_back(preload_q[1]);
      exp_writes.push_back(preload_q[3]);
      exp_writes.push_back(preload_q[4]);
      exp_writes.push_back(new_entry(ev, rnd));
      run_event(ev, 16'd100, rnd, 1);
      compare_results(3'd3);
   endtask

   task automatic test_cancel_match();
      event_msg_t ev;
      logic [RND_WID-1:0] rnd;
      clear_expect();
      preload_q.push_back(mk_entry(EVT_REGULAR, 16'd250, 3'd1, 8'd20));
      preload_q.push_back(mk_entry(EVT_REGULAR, 16'd300, 3'd6, 8'd15));
      preload_q.push_back(mk_entry(EVT_REGULAR, 16'd300, 3'd7, 8'd12));
      load_history(3'd4);
      ev = mk_msg(EVT_CANCEL, 3'd4, 16'd300);
      rnd = make_rnd(4'd15, 3'd2, 6'd63);
      // only the first matching entry annihilates
      exp_msgs.push_back(cancel_of(preload_q[1]));
      exp_writes.push_back(preload_q[0]);
      exp_writes.push_back(preload_q[2]);
      run_event(ev, 16'd100, rnd, 2);
      compare_results(3'd4);
   endtask

   task automatic test_null_messages();
      event_msg_t ev;
      logic [RND_WID-1:0] rnd;
      clear_expect();
      preload_q.push_back(mk_entry(EVT_REGULAR, 16'd380, 3'd2, 8'd30));
      load_history(3'd5);
      ev = mk_msg(EVT_CANCEL, 3'd5, 16'd400);
      rnd = make_rnd(4'd7, 3'd4, 6'd0);
      exp_msgs.push_back(NULL_MSG);
      exp_writes.push_back(preload_q[0]);
      exp_writes.push_back(new_entry(ev, rnd));
      run_event(ev, 16'd300, rnd, 1);
      compare_results(3'd5);

      // stored cancel meets its regular event, nothing is written back
      clear_expect();
      preload_q.push_back(mk_entry(EVT_CANCEL, 16'd500, 3'd1, 8'd10));
      load_history(3'd6);
      ev = mk_msg(EVT_REGULAR, 3'd6, 16'd500);
      rnd = make_rnd(4'd2, 3'd3, 6'd9);
      exp_msgs.push_back(NULL_MSG);
      run_event(ev, 16'd300, rnd, 1);
      compare_results(3'd6);
   endtask

   task automatic test_rollback();
      event_msg_t ev;
      logic [RND_WID-1:0] rnd;
      clear_expect();
      preload_q.push_back(mk_entry(EVT_REGULAR, 16'd550, 3'd1, 8'd20));
      preload_q.push_back(mk_entry(EVT_REGULAR, 16'd650, 3'd2, 8'd30));
      preload_q.push_back(mk_entry(EVT_REGULAR, 16'd700, 3'd3, 8'd40));
      load_history(3'd7);
      ev = mk_msg(EVT_REGULAR, 3'd7, 16'd600);
      rnd = make_rnd(4'd5, 3'd0, 6'd17);
      exp_msgs.push_back(new_event_msg(ev, rnd));
      // each rolled-back entry is cancelled, then re-executed on this LP
      exp_msgs.push_back(cancel_of(preload_q[1]));
      exp_msgs.push_back(mk_msg(EVT_REGULAR, 3'd7, 16'd650));
      exp_msgs.push_back(cancel_of(preload_q[2]));
      exp_msgs.push_back(mk_msg(EVT_REGULAR, 3'd7, 16'd700));
      exp_writes.push_back(preload_q[0]);
      exp_writes.push_back(new_entry(ev, rnd));
      run_event(ev, 16'd500, rnd, 4);
      compare_results(3'd7);
   endtask

   initial begin
      rst = 1'b1;
      event_valid = 1'b0;
      event_msg = '0;
      global_time = '0;
      random_in = '0;
      ack = 1'b0;
      hist_size = '0;
      for (int a = 0; a < 2**ADDR_WID; a++) begin
         mem[a] = hist_entry_t'(32'h5a00_0000 | 32'(a * 3));
      end
      for (int i = 0; i < 8; i++) begin
         lp_size[i] = '0;
      end
      repeat (5) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);

      test_empty_history();
      test_expire_and_keep();
      test_cancel_match();
      test_null_messages();
      test_rollback();

      $display("checks run: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
